/* run_sim.sh */
#!/bin/sh
# Builds the APB timer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_apb_timer \
	--Mdir obj_dir -o tb_apb_timer
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_apb_timer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TB PASSED" "$LOG"; then
	exit 0
fi
exit 1

/* testbench/tb_apb_timer.sv */
// APB timer testbench
// Drives the timer over APB and checks registers, wrap, match, clear and stop behavior

`timescale 1ns/1ns

module tb_apb_timer;

	localparam int CLK_PERIOD    = 20;
	localparam int WRAP_LOAD     = 5;
	localparam int WRAP_PRESCALE = 2;
	localparam int MATCH_LOAD    = 100;
	localparam int MATCH_COMPARE = 3;
	localparam int POLL_MARGIN   = 12;
	// One wrap period and the distance from RELOAD to the first match
	localparam int WRAP_CYCLES   = (WRAP_LOAD + 1) * (WRAP_PRESCALE + 1);
	localparam int MATCH_CYCLES  = (MATCH_COMPARE + 1) * (WRAP_PRESCALE + 1);
	// About 80 two-cycle accesses plus the fixed waits of the stop test
	localparam int ACCESS_CYCLES = 200;
	localparam int WATCHDOG_CYCLES = 5 + ACCESS_CYCLES + 2 * WRAP_CYCLES + MATCH_CYCLES +
		3 * POLL_MARGIN + 100;

	logic        rvx_port_15;
	logic        rvx_port_04;
	logic        psel;
	logic        penable;
	logic [11:0] paddr;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        irq;
	logic [31:0] timer_value;

	integer      seed;
	int          errors;
	int          checks;
	int          test_start;
	int          tests_failed;
	logic [31:0] load_v;
	logic [31:0] cmp_v;
	logic [31:0] pre_v;
	logic [31:0] rd;
	logic [31:0] hold_a;
	logic [31:0] hold_b;
	logic        err;

	apb_timer uut (
		.rvx_port_15 (rvx_port_15),
		.rvx_port_04 (rvx_port_04),
		.psel        (psel),
		.penable     (penable),
		.paddr       (paddr),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.irq         (irq),
		.timer_value (timer_value)
	);

	initial
	begin
		rvx_port_15 = 1'b0;
		forever #(CLK_PERIOD / 2) rvx_port_15 = ~rvx_port_15;
	end

	// ****************************************
	// Check and APB helpers
	// ****************************************
	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_le(input string name, input logic [31:0] got, input logic [31:0] limit);
		checks++;
		assert (got <= limit)
		else
		begin
			$display("MISMATCH %s got 0x%08h above limit 0x%08h", name, got, limit);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1)
		else
		begin
			$display("ERROR %s", what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_start)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: %0d errors", name, errors - test_start);
			tests_failed++;
		end
		test_start = errors;
	endtask

	// Entered 2 ns after a rising edge, and returns 2 ns after one
	task automatic apb_access(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
		output logic [31:0] data, output logic slverr);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge rvx_port_15);
		#2;
		penable = 1'b1;
		#8;
		data   = prdata;
		slverr = pslverr;
		@(posedge rvx_port_15);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_reg(input string name, input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic        slverr;
		apb_access(addr, 1'b1, data, unused, slverr);
		check_eq({name, ".pslverr"}, 32'(slverr), 32'd0);
	endtask

	task automatic read_check(input string name, input logic [11:0] addr, input logic [31:0] exp);
		logic [31:0] data;
		logic        slverr;
		apb_access(addr, 1'b0, 32'd0, data, slverr);
		check_eq(name, data, exp);
		check_eq({name, ".pslverr"}, 32'(slverr), 32'd0);
	endtask

	// Polls STATUS until a flag sets, and keeps the count within LOAD meanwhile
	task automatic wait_flag(input int idx, input int max_cycles, input logic [31:0] max_count,
		input string flag);
		logic [31:0] data;
		logic        slverr;
		int          waited;
		data   = 32'd0;
		waited = 0;
		while (data[idx] !== 1'b1 && waited <= max_cycles)
		begin
			apb_access(timer_pkg::STATUS_OFFSET, 1'b0, 32'd0, data, slverr);
			waited += 2;
			check_le("timer_value", timer_value, max_count);
		end
		check_true(data[idx], $sformatf("%s flag not set within %0d cycles", flag, max_cycles));
	endtask

	// ****************************************
	// Test sequence
	// ****************************************
	initial
	begin
		seed         = 32'h014eaf33;
		errors       = 0;
		checks       = 0;
		test_start   = 0;
		tests_failed = 0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = 12'h000;
		pwdata       = 32'd0;
		rvx_port_04  = 1'b0;
		repeat (5) @(posedge rvx_port_15);
		#2;
		rvx_port_04 = 1'b1;
		@(posedge rvx_port_15);
		#2;

		read_check("LOAD", timer_pkg::LOAD_OFFSET, timer_pkg::LOAD_RESET);
		read_check("COMPARE", timer_pkg::COMPARE_OFFSET, timer_pkg::COMPARE_RESET);
		read_check("PRESCALE", timer_pkg::PRESCALE_OFFSET, timer_pkg::PRESCALE_RESET);
		read_check("STATUS", timer_pkg::STATUS_OFFSET, 32'd0);
		read_check("CMD", timer_pkg::CMD_OFFSET, 32'd0);
		check_eq("irq", 32'(irq), 32'd0);
		check_eq("pready", 32'(pready), 32'd1);
		check_eq("timer_value", timer_value, 32'd0);
		end_test("reset_values");

		load_v = $random(seed);
		cmp_v  = $random(seed);
		pre_v  = $random(seed);
		write_reg("LOAD", timer_pkg::LOAD_OFFSET, load_v);
		write_reg("COMPARE", timer_pkg::COMPARE_OFFSET, cmp_v);
		write_reg("PRESCALE", timer_pkg::PRESCALE_OFFSET, pre_v);
		read_check("LOAD", timer_pkg::LOAD_OFFSET, load_v);
		read_check("COMPARE", timer_pkg::COMPARE_OFFSET, cmp_v);
		read_check("PRESCALE", timer_pkg::PRESCALE_OFFSET, pre_v);
		write_reg("LOAD+1", timer_pkg::LOAD_OFFSET + 12'd1, ~load_v);
		read_check("LOAD after misaligned write", timer_pkg::LOAD_OFFSET, load_v);
		end_test("stored_registers");

		apb_access(12'h014, 1'b0, 32'd0, rd, err);
		check_eq("prdata@0x14", rd, 32'd0);
		check_eq("pslverr@0x14", 32'(err), 32'd1);
		apb_access(12'h040, 1'b1, $random(seed), rd, err);
		check_eq("prdata@0x40 write", rd, 32'd0);
		check_eq("pslverr@0x40", 32'(err), 32'd1);
		apb_access(12'h014, 1'b1, $random(seed), rd, err);
		check_eq("prdata@0x14 write", rd, 32'd0);
		check_eq("pslverr@0x14 write", 32'(err), 32'd1);
		apb_access(12'h040, 1'b0, 32'd0, rd, err);
		check_eq("prdata@0x40", rd, 32'd0);
		read_check("LOAD", timer_pkg::LOAD_OFFSET, load_v);
		read_check("COMPARE", timer_pkg::COMPARE_OFFSET, cmp_v);
		read_check("PRESCALE", timer_pkg::PRESCALE_OFFSET, pre_v);
		end_test("unmapped_offsets");

		write_reg("LOAD", timer_pkg::LOAD_OFFSET, 32'(WRAP_LOAD));
		write_reg("PRESCALE", timer_pkg::PRESCALE_OFFSET, 32'(WRAP_PRESCALE));
		write_reg("COMPARE", timer_pkg::COMPARE_OFFSET, 32'hFFFF_FFFF);
		write_reg("CMD", timer_pkg::CMD_OFFSET, 32'(timer_pkg::CMD_START));
		apb_access(timer_pkg::STATUS_OFFSET, 1'b0, 32'd0, rd, err);
		check_eq("STATUS.STARTED", 32'(rd[timer_pkg::STATUS_STARTED]), 32'd1);
		wait_flag(timer_pkg::STATUS_WRAP, WRAP_CYCLES + POLL_MARGIN, 32'(WRAP_LOAD), "WRAP");
		check_eq("irq", 32'(irq), 32'd1);
		wait_flag(timer_pkg::STATUS_OVERRUN, WRAP_CYCLES + POLL_MARGIN, 32'(WRAP_LOAD),
			"OVERRUN");
		end_test("wrap");

		// A long LOAD keeps the next wrap far away from the clear sequence
		write_reg("LOAD", timer_pkg::LOAD_OFFSET, 32'(MATCH_LOAD));
		write_reg("COMPARE", timer_pkg::COMPARE_OFFSET, 32'(MATCH_COMPARE));
		write_reg("CMD", timer_pkg::CMD_OFFSET, 32'(timer_pkg::CMD_RELOAD));
		wait_flag(timer_pkg::STATUS_MATCH, MATCH_CYCLES + POLL_MARGIN, 32'(MATCH_LOAD), "MATCH");
		write_reg("STATUS", timer_pkg::STATUS_OFFSET, 32'd1 << timer_pkg::STATUS_WRAP);
		apb_access(timer_pkg::STATUS_OFFSET, 1'b0, 32'd0, rd, err);
		check_eq("STATUS.WRAP", 32'(rd[timer_pkg::STATUS_WRAP]), 32'd0);
		check_eq("STATUS.MATCH", 32'(rd[timer_pkg::STATUS_MATCH]), 32'd1);
		check_eq("irq", 32'(irq), 32'd1);
		write_reg("STATUS", timer_pkg::STATUS_OFFSET, 32'd1 << timer_pkg::STATUS_MATCH);
		check_eq("irq", 32'(irq), 32'd0);
		apb_access(timer_pkg::STATUS_OFFSET, 1'b0, 32'd0, rd, err);
		check_eq("STATUS.MATCH", 32'(rd[timer_pkg::STATUS_MATCH]), 32'd0);
		end_test("compare_and_clear");

		write_reg("CMD", timer_pkg::CMD_OFFSET, 32'(timer_pkg::CMD_STOP));
		apb_access(timer_pkg::STATUS_OFFSET, 1'b0, 32'd0, rd, err);
		check_eq("STATUS.STOPPED", 32'(rd[timer_pkg::STATUS_STOPPED]), 32'd1);
		hold_a = timer_value;
		repeat (3 * (WRAP_PRESCALE + 1)) @(posedge rvx_port_15);
		#2;
		hold_b = timer_value;
		check_eq("timer_value held", hold_b, hold_a);
		write_reg("CMD", timer_pkg::CMD_OFFSET, 32'(timer_pkg::CMD_RELOAD));
		check_eq("timer_value after RELOAD", timer_value, 32'd0);
		repeat (4 * (WRAP_PRESCALE + 1)) @(posedge rvx_port_15);
		#2;
		check_eq("timer_value while stopped", timer_value, 32'd0);
		end_test("stop_and_reload");

		$display("tests 6, tests failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* verilog.f */
verilog/timer_pkg.sv
verilog/timer_apb_regs.sv
verilog/timer_prescaler.sv
verilog/timer_counter.sv
verilog/timer_irq_status.sv
verilog/apb_timer.sv
testbench/tb_apb_timer.sv

/* verilog/apb_timer.sv */
// APB timer top level
// Register file, prescaler, counter and status flags behind one APB slave

`timescale 1ns/1ns

module apb_timer #(
	parameter int ADDR_WIDTH     = 12,
	parameter bit BIG_ENDIAN_BUS = 1'b0
) (
	input  logic                  rvx_port_15,
	input  logic                  rvx_port_04,
	input  logic                  psel,
	input  logic                  penable,
	input  logic [ADDR_WIDTH-1:0] paddr,
	input  logic                  pwrite,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  irq,
	output logic [31:0]           timer_value
);

	logic                               cmd_valid;
	timer_pkg::timer_cmd_e              cmd_op;
	logic                               status_clear;
	logic [timer_pkg::STATUS_WIDTH-1:0] status_clear_mask;
	logic [timer_pkg::STATUS_WIDTH-1:0] status_flags;
	logic [31:0]                        load_value;
	logic [31:0]                        compare_value;
	logic [31:0]                        prescale_value;
	logic                               running;
	logic                               tick;
	logic                               wrap;
	logic                               match;
	logic                               started;
	logic                               stopped;

	// ****************************************
	// Bus side
	// ****************************************
	timer_apb_regs #(
		.ADDR_WIDTH     (ADDR_WIDTH),
		.BIG_ENDIAN_BUS (BIG_ENDIAN_BUS)
	) u_regs (
		.rvx_port_15       (rvx_port_15),
		.rvx_port_04       (rvx_port_04),
		.psel              (psel),
		.penable           (penable),
		.paddr             (paddr),
		.pwrite            (pwrite),
		.pwdata            (pwdata),
		.status_flags      (status_flags),
		.prdata            (prdata),
		.pready            (pready),
		.pslverr           (pslverr),
		.cmd_valid         (cmd_valid),
		.cmd_op            (cmd_op),
		.status_clear      (status_clear),
		.status_clear_mask (status_clear_mask),
		.load_value        (load_value),
		.compare_value     (compare_value),
		.prescale_value    (prescale_value)
	);

	// ****************************************
	// Timer core
	// ****************************************
	timer_prescaler u_prescaler (
		.rvx_port_15    (rvx_port_15),
		.rvx_port_04    (rvx_port_04),
		.running        (running),
		.prescale_value (prescale_value),
		.tick           (tick)
	);

	timer_counter u_counter (
		.rvx_port_15   (rvx_port_15),
		.rvx_port_04   (rvx_port_04),
		.cmd_valid     (cmd_valid),
		.cmd_op        (cmd_op),
		.tick          (tick),
		.load_value    (load_value),
		.compare_value (compare_value),
		.running       (running),
		.timer_value   (timer_value),
		.wrap          (wrap),
		.match         (match),
		.started       (started),
		.stopped       (stopped)
	);

	timer_irq_status u_status (
		.rvx_port_15       (rvx_port_15),
		.rvx_port_04       (rvx_port_04),
		.wrap              (wrap),
		.match             (match),
		.started           (started),
		.stopped           (stopped),
		.status_clear      (status_clear),
		.status_clear_mask (status_clear_mask),
		.status_flags      (status_flags),
		.irq               (irq)
	);

endmodule

/* verilog/timer_apb_regs.sv */
// Timer APB register file
// Decodes APB accesses, keeps LOAD, COMPARE and PRESCALE and strobes the core

`timescale 1ns/1ns

module timer_apb_regs #(
	parameter int ADDR_WIDTH     = 12,
	parameter bit BIG_ENDIAN_BUS = 1'b0
) (
	input  logic                                rvx_port_15,
	input  logic                                rvx_port_04,
	input  logic                                psel,
	input  logic                                penable,
	input  logic [ADDR_WIDTH-1:0]               paddr,
	input  logic                                pwrite,
	input  logic [31:0]                         pwdata,
	input  logic [timer_pkg::STATUS_WIDTH-1:0]  status_flags,
	output logic [31:0]                         prdata,
	output logic                                pready,
	output logic                                pslverr,
	output logic                                cmd_valid,
	output timer_pkg::timer_cmd_e               cmd_op,
	output logic                                status_clear,
	output logic [timer_pkg::STATUS_WIDTH-1:0]  status_clear_mask,
	output logic [31:0]                         load_value,
	output logic [31:0]                         compare_value,
	output logic [31:0]                         prescale_value
);

	localparam logic [ADDR_WIDTH-1:0] STATUS_ADDR   = ADDR_WIDTH'(timer_pkg::STATUS_OFFSET);
	localparam logic [ADDR_WIDTH-1:0] LOAD_ADDR     = ADDR_WIDTH'(timer_pkg::LOAD_OFFSET);
	localparam logic [ADDR_WIDTH-1:0] CMD_ADDR      = ADDR_WIDTH'(timer_pkg::CMD_OFFSET);
	localparam logic [ADDR_WIDTH-1:0] COMPARE_ADDR  = ADDR_WIDTH'(timer_pkg::COMPARE_OFFSET);
	localparam logic [ADDR_WIDTH-1:0] PRESCALE_ADDR = ADDR_WIDTH'(timer_pkg::PRESCALE_OFFSET);

	// Reverses the four bytes of a word
	function automatic logic [31:0] swap_bytes(input logic [31:0] d);
		return {d[7:0], d[15:8], d[23:16], d[31:24]};
	endfunction

	logic [ADDR_WIDTH-1:0] word_addr;
	logic                  aligned;
	logic                  wr_access;
	logic [31:0]           wdata;
	logic [31:0]           rdata;
	logic                  unmapped;

	// ****************************************
	// Bus side decode
	// ****************************************
	assign word_addr = {paddr[ADDR_WIDTH-1:2], 2'b00};
	assign aligned   = (paddr[1:0] == 2'b00);

	// Misaligned offsets read normally but never write
	assign wr_access = psel & penable & pwrite & aligned;

	assign wdata  = BIG_ENDIAN_BUS ? swap_bytes(pwdata) : pwdata;
	assign prdata = BIG_ENDIAN_BUS ? swap_bytes(rdata) : rdata;
	assign pready = 1'b1;

	always_comb
	begin
		rdata    = 32'd0;
		unmapped = 1'b0;
		case (word_addr)
			STATUS_ADDR:   rdata = 32'(status_flags);
			LOAD_ADDR:     rdata = load_value;
			CMD_ADDR:      rdata = 32'd0;
			COMPARE_ADDR:  rdata = compare_value;
			PRESCALE_ADDR: rdata = prescale_value;
			default:       unmapped = 1'b1;
		endcase
	end

	assign pslverr = psel & unmapped;

	// ****************************************
	// Strobes to the core
	// ****************************************
	assign cmd_valid         = wr_access & (word_addr == CMD_ADDR);
	assign cmd_op            = timer_pkg::timer_cmd_e'(wdata[1:0]);
	assign status_clear      = wr_access & (word_addr == STATUS_ADDR);
	assign status_clear_mask = wdata[timer_pkg::STATUS_WIDTH-1:0];

	// Stored registers
	always_ff @(posedge rvx_port_15 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			load_value     <= timer_pkg::LOAD_RESET;
			compare_value  <= timer_pkg::COMPARE_RESET;
			prescale_value <= timer_pkg::PRESCALE_RESET;
		end
		else if (wr_access)
		begin
			if (word_addr == LOAD_ADDR)
				load_value <= wdata;
			if (word_addr == COMPARE_ADDR)
				compare_value <= wdata;
			if (word_addr == PRESCALE_ADDR)
				prescale_value <= wdata;
		end
	end

endmodule

/* verilog/timer_counter.sv */
// Timer counter
// Runs commands, counts prescaler ticks, wraps at LOAD and flags compare matches

`timescale 1ns/1ns

module timer_counter (
	input  logic                  rvx_port_15,
	input  logic                  rvx_port_04,
	input  logic                  cmd_valid,
	input  timer_pkg::timer_cmd_e cmd_op,
	input  logic                  tick,
	input  logic [31:0]           load_value,
	input  logic [31:0]           compare_value,
	output logic                  running,
	output logic [31:0]           timer_value,
	output logic                  wrap,
	output logic                  match,
	output logic                  started,
	output logic                  stopped
);

	timer_pkg::timer_state_e state;

	assign running = (state == timer_pkg::TIMER_RUN);

	always_ff @(posedge rvx_port_15 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			state       <= timer_pkg::TIMER_IDLE;
			timer_value <= 32'd0;
			wrap        <= 1'b0;
			match       <= 1'b0;
			started     <= 1'b0;
			stopped     <= 1'b0;
		end
		else
		begin
			// Event outputs are single-cycle pulses
			wrap    <= 1'b0;
			match   <= 1'b0;
			started <= 1'b0;
			stopped <= 1'b0;

			// ****************************************
			// A command takes priority over a tick
			// ****************************************
			if (cmd_valid)
			begin
				case (cmd_op)
					timer_pkg::CMD_START:
					begin
						state       <= timer_pkg::TIMER_RUN;
						timer_value <= 32'd0;
						started     <= 1'b1;
					end
					timer_pkg::CMD_STOP:
					begin
						state   <= timer_pkg::TIMER_IDLE;
						stopped <= 1'b1;
					end
					timer_pkg::CMD_RELOAD:
						timer_value <= 32'd0;
					default:
						state <= state;
				endcase
			end
			else if (running && tick)
			begin
				// Match looks at the count before this tick
				match <= (timer_value == compare_value);
				if (timer_value == load_value)
				begin
					timer_value <= 32'd0;
					wrap        <= 1'b1;
				end
				else
					timer_value <= timer_value + 32'd1;
			end
		end
	end

endmodule

/* verilog/timer_irq_status.sv */
// Timer status flags
// Sticky event flags with write-one-to-clear and the registered interrupt

`timescale 1ns/1ns

module timer_irq_status (
	input  logic                               rvx_port_15,
	input  logic                               rvx_port_04,
	input  logic                               wrap,
	input  logic                               match,
	input  logic                               started,
	input  logic                               stopped,
	input  logic                               status_clear,
	input  logic [timer_pkg::STATUS_WIDTH-1:0] status_clear_mask,
	output logic [timer_pkg::STATUS_WIDTH-1:0] status_flags,
	output logic                               irq
);

	logic [timer_pkg::STATUS_WIDTH-1:0] set_vec;
	logic [timer_pkg::STATUS_WIDTH-1:0] clr_vec;
	logic [timer_pkg::STATUS_WIDTH-1:0] flags_next;

	always_comb
	begin
		set_vec                            = '0;
		set_vec[timer_pkg::STATUS_WRAP]    = wrap;
		set_vec[timer_pkg::STATUS_MATCH]   = match;
		set_vec[timer_pkg::STATUS_STARTED] = started;
		set_vec[timer_pkg::STATUS_STOPPED] = stopped;
		// A second wrap before software has seen the first one
		set_vec[timer_pkg::STATUS_OVERRUN] = wrap & status_flags[timer_pkg::STATUS_WRAP];
	end

	assign clr_vec    = status_clear ? status_clear_mask : '0;
	assign flags_next = (status_flags & ~clr_vec) | set_vec;  // set wins

	always_ff @(posedge rvx_port_15 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			status_flags <= '0;
			irq          <= 1'b0;
		end
		else
		begin
			status_flags <= flags_next;
			irq          <= flags_next[timer_pkg::STATUS_WRAP] |
			                flags_next[timer_pkg::STATUS_MATCH];
		end
	end

endmodule

/* verilog/timer_pkg.sv */
// Timer package
// Register map, reset values and the enums shared by the APB timer blocks

package timer_pkg;

	// ****************************************
	// Register byte offsets
	// ****************************************
	localparam logic [11:0] STATUS_OFFSET   = 12'h000;
	localparam logic [11:0] LOAD_OFFSET     = 12'h004;
	localparam logic [11:0] CMD_OFFSET      = 12'h008;
	localparam logic [11:0] COMPARE_OFFSET  = 12'h00C;
	localparam logic [11:0] PRESCALE_OFFSET = 12'h010;

	// Reset values of the stored registers
	localparam logic [31:0] LOAD_RESET     = 32'hFFFF_FFFF;
	localparam logic [31:0] COMPARE_RESET  = 32'h0000_0000;
	localparam logic [31:0] PRESCALE_RESET = 32'h0000_0000;

	// ****************************************
	// Status flags
	// ****************************************
	localparam int STATUS_WIDTH   = 5;
	localparam int STATUS_WRAP    = 0;
	localparam int STATUS_MATCH   = 1;
	localparam int STATUS_STARTED = 2;
	localparam int STATUS_STOPPED = 3;
	localparam int STATUS_OVERRUN = 4;

	// Opcodes written to CMD, taken from the low two data bits
	typedef enum logic [1:0] {
		CMD_NOP    = 2'd0,
		CMD_START  = 2'd1,
		CMD_STOP   = 2'd2,
		CMD_RELOAD = 2'd3
	} timer_cmd_e;

	typedef enum logic {
		TIMER_IDLE = 1'b0,
		TIMER_RUN  = 1'b1
	} timer_state_e;

endpackage

/* verilog/timer_prescaler.sv */
// Timer prescaler
// Divides the clock by PRESCALE+1 while the timer runs

`timescale 1ns/1ns

module timer_prescaler (
	input  logic        rvx_port_15,
	input  logic        rvx_port_04,
	input  logic        running,
	input  logic [31:0] prescale_value,
	output logic        tick
);

	logic [31:0] div_cnt;

	always_ff @(posedge rvx_port_15 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			div_cnt <= 32'd0;
			tick    <= 1'b0;
		end
		else if (!running)
		begin
			// Held at zero so the first period is a full one
			div_cnt <= 32'd0;
			tick    <= 1'b0;
		end
		else if (div_cnt == prescale_value)
		begin
			div_cnt <= 32'd0;
			tick    <= 1'b1;
		end
		else
		begin
			div_cnt <= div_cnt + 32'd1;
			tick    <= 1'b0;
		end
	end

endmodule
